// ==== logic/prbs_pkg.sv ====
package prbs_pkg;

  // word width with a sequence period of 2**LFSR_BITS - 1
  localparam int LFSR_BITS  = 8;

  // FIFO geometry where depth must be a power of two
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW    = 3;

  // checker word and error counters
  localparam int CNT_BITS   = 16;

  typedef logic [LFSR_BITS-1:0] prbs_word_t;

  // next state of the XNOR LFSR
  // shift left with feedback entering at bit 0
  // taps are numbered from 1 as in the classic tap table
  // all ones is the lock-up state and never a seed
  function automatic prbs_word_t prbs_next(input prbs_word_t state);
    logic [32:1] v;
    logic        fb;
    v = '0;
    v[LFSR_BITS:1] = state;
    case (LFSR_BITS)
      3:  fb = v[3] ^~ v[2];
      4:  fb = v[4] ^~ v[3];
      5:  fb = v[5] ^~ v[3];
      6:  fb = v[6] ^~ v[5];
      7:  fb = v[7] ^~ v[6];
      8:  fb = v[8] ^~ v[6] ^~ v[5] ^~ v[4];
      9:  fb = v[9] ^~ v[5];
      10: fb = v[10] ^~ v[7];
      11: fb = v[11] ^~ v[9];
      12: fb = v[12] ^~ v[6] ^~ v[4] ^~ v[1];
      13: fb = v[13] ^~ v[4] ^~ v[3] ^~ v[1];
      14: fb = v[14] ^~ v[5] ^~ v[3] ^~ v[1];
      15: fb = v[15] ^~ v[14];
      16: fb = v[16] ^~ v[15] ^~ v[13] ^~ v[4];
      17: fb = v[17] ^~ v[14];
      18: fb = v[18] ^~ v[11];
      19: fb = v[19] ^~ v[6] ^~ v[2] ^~ v[1];
      20: fb = v[20] ^~ v[17];
      21: fb = v[21] ^~ v[19];
      22: fb = v[22] ^~ v[21];
      23: fb = v[23] ^~ v[18];
      24: fb = v[24] ^~ v[23] ^~ v[22] ^~ v[17];
      25: fb = v[25] ^~ v[22];
      26: fb = v[26] ^~ v[6] ^~ v[2] ^~ v[1];
      27: fb = v[27] ^~ v[5] ^~ v[2] ^~ v[1];
      28: fb = v[28] ^~ v[25];
      29: fb = v[29] ^~ v[27];
      30: fb = v[30] ^~ v[6] ^~ v[4] ^~ v[1];
      31: fb = v[31] ^~ v[28];
      32: fb = v[32] ^~ v[22] ^~ v[2] ^~ v[1];
      // widths outside the table are not supported
      default: fb = 1'b0;
    endcase
    return {state[LFSR_BITS-2:0], fb};
  endfunction

endpackage

// ==== logic/lfsr_gen.sv ====
`timescale 1ns/1ps

module lfsr_gen (
  input  logic                 i_Clk,
  input  logic                 i_rst_n,
  input  logic                 i_enable,
  input  logic                 i_seed_dv,
  input  prbs_pkg::prbs_word_t i_seed_data,
  input  logic                 i_inject_err,
  input  logic                 i_full,
  output logic                 o_wr_en,
  output prbs_pkg::prbs_word_t o_wr_data,
  output logic                 o_wrap
);
  import prbs_pkg::*;

  prbs_word_t r_state;
  prbs_word_t r_seed;
  prbs_word_t state_next;
  logic       r_err_pend;

  assign state_next = prbs_next(r_state);

  // one word per cycle unless full or a seed load pauses it
  assign o_wr_en = i_enable && !i_seed_dv && !i_full;

  // injected error flips bit 0 of the written copy only
  assign o_wr_data = {r_state[LFSR_BITS-1:1], r_state[0] ^ r_err_pend};

  // state and the seed it started from
  always_ff @(posedge i_Clk) begin
    if (!i_rst_n) begin
      r_state <= '0;
      r_seed  <= '0;
    end else if (i_seed_dv) begin
      r_state <= i_seed_data;
      r_seed  <= i_seed_data;
    end else if (o_wr_en) begin
      r_state <= state_next;
    end
  end

  // pending error waits for the next write
  always_ff @(posedge i_Clk) begin
    if (!i_rst_n) begin
      r_err_pend <= 1'b0;
    end else if (i_inject_err) begin
      r_err_pend <= 1'b1;
    end else if (o_wr_en) begin
      r_err_pend <= 1'b0;
    end
  end

  // wrap pulse once per full period
  always_ff @(posedge i_Clk) begin
    if (!i_rst_n) begin
      o_wrap <= 1'b0;
    end else begin
      o_wrap <= o_wr_en && (state_next == r_seed);
    end
  end

endmodule

// ==== logic/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo (
  input  logic                 i_Clk,
  input  logic                 i_rst_n,
  input  logic                 i_flush,
  input  logic                 i_wr_en,
  input  prbs_pkg::prbs_word_t i_wr_data,
  input  logic                 i_rd_en,
  output prbs_pkg::prbs_word_t o_rd_data,
  output logic                 o_full,
  output logic                 o_empty
);
  import prbs_pkg::*;

  prbs_word_t         r_mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] r_wr_ptr;
  logic [FIFO_AW-1:0] r_rd_ptr;
  logic [FIFO_AW:0]   r_count;

  // flags straight from the occupancy count
  assign o_full  = (r_count == (FIFO_AW+1)'(FIFO_DEPTH));
  assign o_empty = (r_count == '0);

  // storage and registered read port
  always_ff @(posedge i_Clk) begin
    if (i_wr_en) begin
      r_mem[r_wr_ptr] <= i_wr_data;
    end
    if (i_rd_en) begin
      o_rd_data <= r_mem[r_rd_ptr];
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge i_Clk) begin
    if (!i_rst_n || i_flush) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
    end else begin
      if (i_wr_en) begin
        r_wr_ptr <= r_wr_ptr + 1'b1;
      end
      if (i_rd_en) begin
        r_rd_ptr <= r_rd_ptr + 1'b1;
      end
    end
  end

  // occupancy, unchanged on a simultaneous read and write
  always_ff @(posedge i_Clk) begin
    if (!i_rst_n || i_flush) begin
      r_count <= '0;
    end else begin
      case ({i_wr_en, i_rd_en})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  // producer must respect full
  a_no_overflow: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
    i_wr_en |-> !o_full);

  // consumer must respect empty
  a_no_underflow: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
    i_rd_en |-> !o_empty);

endmodule

// ==== logic/prbs_checker.sv ====
`timescale 1ns/1ps

module prbs_checker (
  input  logic                             i_Clk,
  input  logic                             i_rst_n,
  input  logic                             i_relock,
  input  logic                             i_sink_ready,
  input  logic                             i_empty,
  input  prbs_pkg::prbs_word_t             i_rd_data,
  output logic                             o_rd_en,
  output logic                             o_rx_valid,
  output prbs_pkg::prbs_word_t             o_rx_data,
  output logic                             o_locked,
  output logic [prbs_pkg::CNT_BITS-1:0]    o_word_count,
  output logic [prbs_pkg::CNT_BITS-1:0]    o_err_count
);
  import prbs_pkg::*;

  prbs_word_t r_expect;
  prbs_word_t exp_next;
  logic       r_vld;

  // no read during relock, so no old-stream word reaches the new lock
  assign o_rd_en = i_sink_ready && !i_empty && !i_relock;

  // FIFO read data is registered and valid the cycle after the read
  assign o_rx_valid = r_vld;
  assign o_rx_data  = i_rd_data;

  // prediction runs off the expected word and not the received one
  assign exp_next = prbs_next(r_expect);

  always_ff @(posedge i_Clk) begin
    if (!i_rst_n) begin
      r_vld <= 1'b0;
    end else begin
      r_vld <= o_rd_en;
    end
  end

  // lock state and counters update when a received word is consumed
  always_ff @(posedge i_Clk) begin
    if (!i_rst_n || i_relock) begin
      o_locked     <= 1'b0;
      o_word_count <= '0;
      o_err_count  <= '0;
    end else if (r_vld) begin
      o_word_count <= o_word_count + 1'b1;
      if (!o_locked) begin
        o_locked <= 1'b1;
      end else if (i_rd_data != exp_next) begin
        o_err_count <= o_err_count + 1'b1;
      end
    end
  end

  // first word seeds the reference and then the reference just steps
  // so a single bad word costs exactly one error
  always_ff @(posedge i_Clk) begin
    if (r_vld) begin
      if (o_locked) begin
        r_expect <= exp_next;
      end else begin
        r_expect <= i_rd_data;
      end
    end
  end

  // counters only move up between relocks
  a_cnt_no_wrap: assert property (@(posedge i_Clk) disable iff (!i_rst_n)
    !i_relock |=> (o_word_count >= $past(o_word_count)) &&
                  (o_err_count >= $past(o_err_count)));

endmodule

// ==== logic/prbs_top.sv ====
`timescale 1ns/1ps

module prbs_top (
  input  logic                          i_Clk,
  input  logic                          i_rst_n,
  input  logic                          i_enable,
  input  logic                          i_seed_dv,
  input  prbs_pkg::prbs_word_t          i_seed_data,
  input  logic                          i_inject_err,
  input  logic                          i_sink_ready,
  output logic                          o_rx_valid,
  output prbs_pkg::prbs_word_t          o_rx_data,
  output logic                          o_locked,
  output logic [prbs_pkg::CNT_BITS-1:0] o_word_count,
  output logic [prbs_pkg::CNT_BITS-1:0] o_err_count,
  output logic                          o_wrap
);
  import prbs_pkg::*;

  // generator to FIFO
  logic       wr_en;
  prbs_word_t wr_data;
  logic       full;

  // FIFO to checker
  logic       rd_en;
  prbs_word_t rd_data;
  logic       empty;

  lfsr_gen u_gen (
    .i_Clk        (i_Clk),
    .i_rst_n      (i_rst_n),
    .i_enable     (i_enable),
    .i_seed_dv    (i_seed_dv),
    .i_seed_data  (i_seed_data),
    .i_inject_err (i_inject_err),
    .i_full       (full),
    .o_wr_en      (wr_en),
    .o_wr_data    (wr_data),
    .o_wrap       (o_wrap)
  );

  // a new seed also drops whatever is still buffered
  sync_fifo u_fifo (
    .i_Clk     (i_Clk),
    .i_rst_n   (i_rst_n),
    .i_flush   (i_seed_dv),
    .i_wr_en   (wr_en),
    .i_wr_data (wr_data),
    .i_rd_en   (rd_en),
    .o_rd_data (rd_data),
    .o_full    (full),
    .o_empty   (empty)
  );

  prbs_checker u_chk (
    .i_Clk        (i_Clk),
    .i_rst_n      (i_rst_n),
    .i_relock     (i_seed_dv),
    .i_sink_ready (i_sink_ready),
    .i_empty      (empty),
    .i_rd_data    (rd_data),
    .o_rd_en      (rd_en),
    .o_rx_valid   (o_rx_valid),
    .o_rx_data    (o_rx_data),
    .o_locked     (o_locked),
    .o_word_count (o_word_count),
    .o_err_count  (o_err_count)
  );

endmodule

// ==== verification/prbs_tb.sv ====
`timescale 1ns/1ps

module prbs_tb;
  import prbs_pkg::*;

  localparam int N_TESTS      = 5;
  localparam int RESET_CYCLES = 5;
  // drain wait plus seed strobe and some slack in cycles
  localparam int DRAIN_MARGIN = 3*FIFO_DEPTH + 10;

  logic                i_Clk;
  logic                i_rst_n;
  logic                i_enable;
  logic                i_seed_dv;
  prbs_word_t          i_seed_data;
  logic                i_inject_err;
  logic                i_sink_ready;
  logic                o_rx_valid;
  prbs_word_t          o_rx_data;
  logic                o_locked;
  logic [CNT_BITS-1:0] o_word_count;
  logic [CNT_BITS-1:0] o_err_count;
  logic                o_wrap;

  // stimulus and expected values with one column per test
  // prefill stuffs the FIFO with old words before the seed strobe
  string      t_name      [N_TESTS] = '{"sequence", "period", "backpressure", "inject", "reseed"};
  prbs_word_t t_seed      [N_TESTS] = '{8'h01, 8'h5a, 8'hc3, 8'h2e, 8'h97};
  int         t_cycles    [N_TESTS] = '{40, 300, 200, 60, 50};
  bit         t_rand_sink [N_TESTS] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b1};
  int         t_inject_at [N_TESTS] = '{-1, -1, -1, 20, -1};
  int         t_prefill   [N_TESTS] = '{0, 0, 0, 0, 6};
  int         t_exp_err   [N_TESTS] = '{0, 0, 0, 1, 0};

  // monitor state
  string       cur_test;
  int          cur_idx = -1;
  prbs_word_t  exp_word;
  int          rx_count;
  int          bad_words;
  bit          wrap_seen;

  int          cycle_cnt = 0;
  int          timeout_limit = 0;
  int          err_cnt = 0;
  logic [31:0] lcg_state;

  prbs_top u_prbs_top (
    .i_Clk        (i_Clk),
    .i_rst_n      (i_rst_n),
    .i_enable     (i_enable),
    .i_seed_dv    (i_seed_dv),
    .i_seed_data  (i_seed_data),
    .i_inject_err (i_inject_err),
    .i_sink_ready (i_sink_ready),
    .o_rx_valid   (o_rx_valid),
    .o_rx_data    (o_rx_data),
    .o_locked     (o_locked),
    .o_word_count (o_word_count),
    .o_err_count  (o_err_count),
    .o_wrap       (o_wrap)
  );

  always #2 i_Clk = ~i_Clk;

  // 8-bit XNOR LFSR with taps 8 6 5 4
  // new bit enters at bit 0
  function automatic prbs_word_t ref_next(input prbs_word_t s);
    logic fb;
    fb = ~(s[7] ^ s[5] ^ s[4] ^ s[3]);
    return {s[6:0], fb};
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      err_cnt++;
      $display("ERR %s %s: expected %0h actual %0h", cur_test, what, expected, actual);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
    end
  endtask

  // received stream checked against the model at mid-cycle
  always @(negedge i_Clk) begin
    if (cur_idx >= 0) begin
      if (o_wrap) begin
        wrap_seen = 1'b1;
      end
      if (o_rx_valid) begin
        if (t_inject_at[cur_idx] < 0) begin
          check("rx data", 32'(exp_word), 32'(o_rx_data));
        end else if (o_rx_data != exp_word) begin
          // corruption must be confined to bit 0
          check("corrupted bits", 32'd1, 32'(o_rx_data ^ exp_word));
          bad_words++;
        end
        if (rx_count > 0) begin
          check("locked after first word", 32'd1, 32'(o_locked));
        end
        if (rx_count == 255) begin
          check("word 255 is the seed", 32'(t_seed[cur_idx]), 32'(o_rx_data));
        end
        if (t_exp_err[cur_idx] == 0) begin
          check("err count in stream", 32'd0, 32'(o_err_count));
        end
        exp_word = ref_next(exp_word);
        rx_count++;
      end
    end
  end

  always @(posedge i_Clk) begin
    cycle_cnt++;
    if (cycle_cnt > timeout_limit) begin
      $display("timeout: run did not finish within %0d cycles", timeout_limit);
      $display("FAIL: see errors above");
      $fatal(1, "timeout");
    end
  end

  task automatic run_test(input int idx);
    int quiet;
    cur_test = t_name[idx];
    i_enable = 1'b1;
    i_sink_ready = 1'b0;
    repeat (t_prefill[idx]) begin
      @(posedge i_Clk);
      #1;
    end
    // model restarts from the seed on the strobe
    i_enable = 1'b0;
    i_seed_dv = 1'b1;
    i_seed_data = t_seed[idx];
    exp_word = t_seed[idx];
    rx_count = 0;
    bad_words = 0;
    wrap_seen = 1'b0;
    cur_idx = idx;
    @(posedge i_Clk);
    #1;
    i_seed_dv = 1'b0;
    check("word count after seed", 32'd0, 32'(o_word_count));
    check("err count after seed", 32'd0, 32'(o_err_count));
    check("locked after seed", 32'd0, 32'(o_locked));
    for (int i = 0; i < t_cycles[idx]; i++) begin
      i_enable = 1'b1;
      i_inject_err = (i == t_inject_at[idx]);
      if (t_rand_sink[idx]) begin
        lcg_state = lcg_next(lcg_state);
        i_sink_ready = lcg_state[16];
      end else begin
        i_sink_ready = 1'b1;
      end
      @(posedge i_Clk);
      #1;
    end
    // drain until the output has been idle for a while
    i_enable = 1'b0;
    i_inject_err = 1'b0;
    i_sink_ready = 1'b1;
    quiet = 0;
    while (quiet < FIFO_DEPTH + 2) begin
      @(posedge i_Clk);
      #1;
      if (o_rx_valid) begin
        quiet = 0;
      end else begin
        quiet++;
      end
    end
    check("words vs valid pulses", 32'(rx_count), 32'(o_word_count));
    check("final err count", 32'(t_exp_err[idx]), 32'(o_err_count));
    check("final lock", 32'(rx_count > 0), 32'(o_locked));
    if (t_inject_at[idx] >= 0) begin
      check("corrupted words", 32'd1, 32'(bad_words));
    end
    // a wrap needs a full period of writes
    check("wrap seen", 32'(rx_count >= 255), 32'(wrap_seen));
    cur_idx = -1;
  endtask

  initial begin
    i_Clk = 1'b0;
    i_rst_n = 1'b0;
    i_enable = 1'b0;
    i_seed_dv = 1'b0;
    i_seed_data = '0;
    i_inject_err = 1'b0;
    i_sink_ready = 1'b0;
    lcg_state = 32'h8385;
    timeout_limit = RESET_CYCLES;
    for (int k = 0; k < N_TESTS; k++) begin
      timeout_limit += t_cycles[k] + t_prefill[k] + DRAIN_MARGIN;
    end
    timeout_limit *= 2;
    cur_test = "reset";
    repeat (RESET_CYCLES) @(posedge i_Clk);
    #1;
    i_rst_n = 1'b1;
    check("rx valid", 32'd0, 32'(o_rx_valid));
    check("locked", 32'd0, 32'(o_locked));
    check("word count", 32'd0, 32'(o_word_count));
    check("err count", 32'd0, 32'(o_err_count));
    check("wrap", 32'd0, 32'(o_wrap));
    for (int k = 0; k < N_TESTS; k++) begin
      run_test(k);
    end
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== files.f ====
logic/prbs_pkg.sv
logic/lfsr_gen.sv
logic/sync_fifo.sv
logic/prbs_checker.sv
logic/prbs_top.sv
verification/prbs_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the PRBS testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module prbs_tb -f files.f -o prbs_sim \
  && ./obj_dir/prbs_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "PASS: all tests" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
exit 0
